/* logic/cpu_isa_pkg.sv */
`default_nettype none

package cpu_isa_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [15:0] addr_t;
    typedef logic [2:0]  reg_idx_t;

    // Register numbers as coded in opcode fields
    localparam reg_idx_t reg_b   = 3'd0;
    localparam reg_idx_t reg_c   = 3'd1;
    localparam reg_idx_t reg_d   = 3'd2;
    localparam reg_idx_t reg_e   = 3'd3;
    localparam reg_idx_t reg_h   = 3'd4;
    localparam reg_idx_t reg_l   = 3'd5;
    localparam reg_idx_t reg_mem = 3'd6; // Memory at HL
    localparam reg_idx_t reg_a   = 3'd7;

    typedef enum logic [2:0] {
        alu_add, alu_adc, alu_sub, alu_sbc,
        alu_and, alu_xor, alu_or,  alu_cp
    } alu_op_t;

    typedef enum logic [1:0] {cond_nz, cond_z, cond_nc, cond_c} cond_t;

    typedef struct packed {
        logic z;
        logic n;
        logic h;
        logic c;
    } flags_t;

    localparam byte_t op_nop  = 8'h00;
    localparam byte_t op_halt = 8'h76;
    localparam byte_t op_jp   = 8'hC3;

    // Major groups in bits 7:6
    localparam logic [1:0] grp_misc = 2'b00; // NOP, LD r,n
    localparam logic [1:0] grp_ld   = 2'b01; // LD r,r' and HALT
    localparam logic [1:0] grp_alu  = 2'b10; // ALU A,r
    localparam logic [1:0] grp_ctl  = 2'b11; // ALU A,n and jumps

    localparam logic [2:0] sub_imm   = 3'b110; // Immediate byte follows
    localparam logic [2:0] sub_jp_cc = 3'b010; // Condition in bits 4:3

    localparam addr_t reset_pc = 16'h0000;

endpackage

`default_nettype wire

/* logic/cpu_ctrl_pkg.sv */
`default_nettype none

package cpu_ctrl_pkg;

    typedef enum logic [3:0] {
        fetch,
        read_imm,
        read_lo,
        read_hi,
        execute,
        mem_read,
        mem_write,
        jump,
        halted
    } seq_state_t;

    typedef enum logic {addr_pc, addr_hl} addr_sel_t;

    typedef enum logic [1:0] {
        wr_bus,    // Read data from memory
        wr_imm,    // Immediate buffer
        wr_alu,    // ALU result into A
        wr_port_b  // Register move
    } wr_src_t;

    typedef struct packed {
        addr_sel_t addr_sel;
        wr_src_t   wr_src;
        logic      reg_wr;
        logic      flag_wr;
        logic      use_imm;   // ALU operand B from the immediate
        logic      imm_load;
        logic      addr_load;
        logic      pc_inc;
        logic      pc_load;
        logic      nread;     // Active low
        logic      nwrite;    // Active low
    } ctrl_t;

    // No bus cycle, nothing written
    localparam ctrl_t ctrl_idle = '{
        addr_sel:  addr_pc,
        wr_src:    wr_port_b,
        reg_wr:    1'b0,
        flag_wr:   1'b0,
        use_imm:   1'b0,
        imm_load:  1'b0,
        addr_load: 1'b0,
        pc_inc:    1'b0,
        pc_load:   1'b0,
        nread:     1'b1,
        nwrite:    1'b1
    };

endpackage

`default_nettype wire

/* logic/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  cpu_isa_pkg::byte_t   a,
    input  cpu_isa_pkg::byte_t   b,
    input  logic                 carry_in,
    input  cpu_isa_pkg::alu_op_t op,
    output cpu_isa_pkg::byte_t   result,
    output cpu_isa_pkg::flags_t  flags_out
);

    logic       cin;
    logic [8:0] arith;  // Bit 8 is carry or borrow
    logic [4:0] half;

    always_comb
    begin
        cin       = carry_in && (op == cpu_isa_pkg::alu_adc || op == cpu_isa_pkg::alu_sbc);
        arith     = '0;
        half      = '0;
        result    = a;
        flags_out = '0;
        case (op)
            cpu_isa_pkg::alu_add, cpu_isa_pkg::alu_adc:
            begin
                arith       = {1'b0, a} + {1'b0, b} + {8'd0, cin};
                half        = {1'b0, a[3:0]} + {1'b0, b[3:0]} + {4'd0, cin};
                result      = arith[7:0];
                flags_out.c = arith[8];
                flags_out.h = half[4];
            end
            cpu_isa_pkg::alu_sub, cpu_isa_pkg::alu_sbc, cpu_isa_pkg::alu_cp:
            begin
                arith       = {1'b0, a} - {1'b0, b} - {8'd0, cin};
                half        = {1'b0, a[3:0]} - {1'b0, b[3:0]} - {4'd0, cin};
                result      = (op == cpu_isa_pkg::alu_cp) ? a : arith[7:0];
                flags_out.n = 1'b1;
                flags_out.c = arith[8];
                flags_out.h = half[4];
            end
            cpu_isa_pkg::alu_and:
            begin
                result      = a & b;
                flags_out.h = 1'b1;
            end
            cpu_isa_pkg::alu_xor: result = a ^ b;
            default:              result = a | b;
        endcase
        // CP leaves A alone, so Z comes from the difference
        if (op == cpu_isa_pkg::alu_cp)
            flags_out.z = (arith[7:0] == 8'd0);
        else
            flags_out.z = (result == 8'd0);
    end

endmodule

`default_nettype wire

/* logic/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic                  clock,
    input  logic                  arst_n,
    input  cpu_isa_pkg::reg_idx_t rd_idx_a,
    input  cpu_isa_pkg::reg_idx_t rd_idx_b,
    input  cpu_isa_pkg::reg_idx_t wr_idx,
    input  logic                  wr_en,
    input  cpu_isa_pkg::byte_t    wr_data,
    output cpu_isa_pkg::byte_t    rd_a,
    output cpu_isa_pkg::byte_t    rd_b,
    output cpu_isa_pkg::addr_t    hl
);

    cpu_isa_pkg::byte_t regs [8]; // Slot six never written, reads zero

    always_ff @(posedge clock or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int i = 0; i < 8; i++)
                regs[i] <= '0;
        end
        else if (wr_en && wr_idx != cpu_isa_pkg::reg_mem)
        begin
            regs[wr_idx] <= wr_data;
        end
    end

    assign rd_a = regs[rd_idx_a];
    assign rd_b = regs[rd_idx_b];
    assign hl   = {regs[cpu_isa_pkg::reg_h], regs[cpu_isa_pkg::reg_l]};

    // Decode must route (HL) destinations to a memory cycle instead
    a_no_mem_write: assert property (@(posedge clock) disable iff (!arst_n)
        wr_en |-> wr_idx != cpu_isa_pkg::reg_mem)
        else $error("reg_file write to index reg_mem");

endmodule

`default_nettype wire

/* logic/datapath.sv */
`timescale 1ns/1ps
`default_nettype none

module datapath (
    input  logic                 clock,
    input  logic                 arst_n,
    input  cpu_ctrl_pkg::ctrl_t  ctrl,
    input  cpu_isa_pkg::byte_t   opcode,
    input  cpu_isa_pkg::byte_t   db_rdata,
    output cpu_isa_pkg::addr_t   db_address,
    output cpu_isa_pkg::byte_t   db_wdata,
    output cpu_isa_pkg::flags_t  flags
);

    cpu_isa_pkg::addr_t    pc;
    cpu_isa_pkg::addr_t    addr_buf;
    cpu_isa_pkg::byte_t    imm_buf;
    cpu_isa_pkg::addr_t    hl;
    cpu_isa_pkg::byte_t    rd_a;
    cpu_isa_pkg::byte_t    rd_b;
    cpu_isa_pkg::byte_t    alu_b;
    cpu_isa_pkg::byte_t    alu_result;
    cpu_isa_pkg::flags_t   alu_flags;
    cpu_isa_pkg::byte_t    wr_data;
    cpu_isa_pkg::reg_idx_t wr_idx;

    always_ff @(posedge clock or negedge arst_n)
    begin
        if (!arst_n)
        begin
            pc    <= cpu_isa_pkg::reset_pc;
            flags <= '0;
        end
        else
        begin
            if (ctrl.pc_load)
                pc <= addr_buf;
            else if (ctrl.pc_inc)
                pc <= pc + 16'd1;
            if (ctrl.flag_wr)
                flags <= alu_flags;
        end
    end

    always_ff @(posedge clock)
    begin
        if (ctrl.imm_load)
            imm_buf <= db_rdata;
        // Shift up, so the first operand byte lands in the high half
        if (ctrl.addr_load)
            addr_buf <= {addr_buf[7:0], db_rdata};
    end

    always_comb
    begin
        case (ctrl.wr_src)
            cpu_ctrl_pkg::wr_bus: wr_data = db_rdata;
            cpu_ctrl_pkg::wr_imm: wr_data = imm_buf;
            cpu_ctrl_pkg::wr_alu: wr_data = alu_result;
            default:              wr_data = rd_b;
        endcase
    end

    // ALU results always go to A
    assign wr_idx = (ctrl.wr_src == cpu_ctrl_pkg::wr_alu) ? cpu_isa_pkg::reg_a : opcode[5:3];
    assign alu_b  = ctrl.use_imm ? imm_buf : rd_b;

    assign db_address = (ctrl.addr_sel == cpu_ctrl_pkg::addr_hl) ? hl : pc;
    assign db_wdata   = rd_b;

    reg_file u_reg_file (
        .clock    (clock),
        .arst_n   (arst_n),
        .rd_idx_a (cpu_isa_pkg::reg_a),
        .rd_idx_b (opcode[2:0]),
        .wr_idx   (wr_idx),
        .wr_en    (ctrl.reg_wr),
        .wr_data  (wr_data),
        .rd_a     (rd_a),
        .rd_b     (rd_b),
        .hl       (hl)
    );

    alu u_alu (
        .a         (rd_a),
        .b         (alu_b),
        .carry_in  (flags.c),
        .op        (cpu_isa_pkg::alu_op_t'(opcode[5:3])),
        .result    (alu_result),
        .flags_out (alu_flags)
    );

    a_pc_one_source: assert property (@(posedge clock) disable iff (!arst_n)
        !(ctrl.pc_load && ctrl.pc_inc))
        else $error("pc_load and pc_inc in the same cycle");

endmodule

`default_nettype wire

/* logic/sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module sequencer (
    input  logic                 clock,
    input  logic                 arst_n,
    input  cpu_isa_pkg::byte_t   db_rdata,
    input  cpu_isa_pkg::flags_t  flags,
    output cpu_ctrl_pkg::ctrl_t  ctrl,
    output cpu_isa_pkg::byte_t   opcode,
    output logic                 db_nread,
    output logic                 db_nwrite,
    output logic                 halted
);

    cpu_ctrl_pkg::seq_state_t state;
    cpu_ctrl_pkg::seq_state_t state_next;
    logic                     cond_met;
    logic                     jump_taken;
    logic                     imm_form;

    // Reset parks a NOP in execute, so one idle cycle precedes the first fetch
    always_ff @(posedge clock or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state  <= cpu_ctrl_pkg::execute;
            opcode <= cpu_isa_pkg::op_nop;
        end
        else
        begin
            state <= state_next;
            if (state == cpu_ctrl_pkg::fetch)
                opcode <= db_rdata;
        end
    end

    always_comb
    begin
        cond_met = 1'b0;
        case (cpu_isa_pkg::cond_t'(opcode[4:3]))
            cpu_isa_pkg::cond_nz: cond_met = !flags.z;
            cpu_isa_pkg::cond_z:  cond_met = flags.z;
            cpu_isa_pkg::cond_nc: cond_met = !flags.c;
            default:              cond_met = flags.c;
        endcase
    end

    assign jump_taken = (opcode == cpu_isa_pkg::op_jp) || cond_met;
    assign imm_form   = (opcode[2:0] == cpu_isa_pkg::sub_imm);

    // Decode straight off the bus while the opcode is being fetched
    always_comb
    begin
        state_next = state;
        case (state)
            cpu_ctrl_pkg::fetch:
            begin
                state_next = cpu_ctrl_pkg::execute;
                if (db_rdata == cpu_isa_pkg::op_halt)
                    state_next = cpu_ctrl_pkg::halted;
                else if (db_rdata[7:6] == cpu_isa_pkg::grp_ld)
                begin
                    if (db_rdata[5:3] == cpu_isa_pkg::reg_mem)
                        state_next = cpu_ctrl_pkg::mem_write;
                    else if (db_rdata[2:0] == cpu_isa_pkg::reg_mem)
                        state_next = cpu_ctrl_pkg::mem_read;
                end
                else if (db_rdata[7:6] != cpu_isa_pkg::grp_alu)
                begin
                    if (db_rdata[2:0] == cpu_isa_pkg::sub_imm)
                        state_next = cpu_ctrl_pkg::read_imm;
                    else if (db_rdata == cpu_isa_pkg::op_jp
                             || (db_rdata[7:6] == cpu_isa_pkg::grp_ctl && !db_rdata[5]
                                 && db_rdata[2:0] == cpu_isa_pkg::sub_jp_cc))
                        state_next = cpu_ctrl_pkg::read_lo;
                end
            end
            cpu_ctrl_pkg::read_imm: state_next = cpu_ctrl_pkg::execute;
            cpu_ctrl_pkg::read_lo:  state_next = cpu_ctrl_pkg::read_hi;
            cpu_ctrl_pkg::read_hi:  state_next = cpu_ctrl_pkg::jump;
            cpu_ctrl_pkg::halted:   state_next = cpu_ctrl_pkg::halted;
            default:                state_next = cpu_ctrl_pkg::fetch;
        endcase
    end

    always_comb
    begin
        ctrl = cpu_ctrl_pkg::ctrl_idle;
        case (state)
            cpu_ctrl_pkg::fetch:
            begin
                ctrl.nread  = 1'b0;
                ctrl.pc_inc = 1'b1;
            end
            cpu_ctrl_pkg::read_imm:
            begin
                ctrl.nread    = 1'b0;
                ctrl.pc_inc   = 1'b1;
                ctrl.imm_load = 1'b1;
            end
            cpu_ctrl_pkg::read_lo, cpu_ctrl_pkg::read_hi:
            begin
                ctrl.nread     = 1'b0;
                ctrl.pc_inc    = 1'b1;
                ctrl.addr_load = 1'b1;
            end
            cpu_ctrl_pkg::execute:
            begin
                case (opcode[7:6])
                    cpu_isa_pkg::grp_misc:
                    begin
                        ctrl.wr_src = cpu_ctrl_pkg::wr_imm;
                        ctrl.reg_wr = imm_form && opcode[5:3] != cpu_isa_pkg::reg_mem;
                    end
                    cpu_isa_pkg::grp_ld: ctrl.reg_wr = 1'b1;
                    cpu_isa_pkg::grp_alu:
                    begin
                        ctrl.wr_src  = cpu_ctrl_pkg::wr_alu;
                        ctrl.reg_wr  = 1'b1;
                        ctrl.flag_wr = 1'b1;
                    end
                    default:
                    begin
                        ctrl.wr_src  = cpu_ctrl_pkg::wr_alu;
                        ctrl.use_imm = 1'b1;
                        ctrl.reg_wr  = imm_form;
                        ctrl.flag_wr = imm_form;
                    end
                endcase
            end
            cpu_ctrl_pkg::mem_read:
            begin
                ctrl.addr_sel = cpu_ctrl_pkg::addr_hl;
                ctrl.nread    = 1'b0;
                ctrl.wr_src   = cpu_ctrl_pkg::wr_bus;
                ctrl.reg_wr   = 1'b1;
            end
            cpu_ctrl_pkg::mem_write:
            begin
                ctrl.addr_sel = cpu_ctrl_pkg::addr_hl;
                ctrl.nwrite   = 1'b0;
            end
            cpu_ctrl_pkg::jump: ctrl.pc_load = jump_taken;
            default: ;
        endcase
    end

    assign db_nread  = ctrl.nread;
    assign db_nwrite = ctrl.nwrite;
    assign halted    = (state == cpu_ctrl_pkg::halted);

    a_one_strobe: assert property (@(posedge clock) disable iff (!arst_n)
        db_nread || db_nwrite)
        else $error("read and write strobes low together");

endmodule

`default_nettype wire

/* logic/cpu_core.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_core (
    input  logic               clock,
    input  logic               arst_n,
    input  cpu_isa_pkg::byte_t db_rdata,
    output cpu_isa_pkg::addr_t db_address,
    output cpu_isa_pkg::byte_t db_wdata,
    output logic               db_nread,
    output logic               db_nwrite,
    output logic               halted
);

    cpu_ctrl_pkg::ctrl_t ctrl;
    cpu_isa_pkg::byte_t  opcode;
    cpu_isa_pkg::flags_t flags;

    sequencer u_sequencer (
        .clock     (clock),
        .arst_n    (arst_n),
        .db_rdata  (db_rdata),
        .flags     (flags),
        .ctrl      (ctrl),
        .opcode    (opcode),
        .db_nread  (db_nread),
        .db_nwrite (db_nwrite),
        .halted    (halted)
    );

    datapath u_datapath (
        .clock      (clock),
        .arst_n     (arst_n),
        .ctrl       (ctrl),
        .opcode     (opcode),
        .db_rdata   (db_rdata),
        .db_address (db_address),
        .db_wdata   (db_wdata),
        .flags      (flags)
    );

endmodule

`default_nettype wire

/* bench/bench_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module bench_memory (
    input  logic               clock,
    input  cpu_isa_pkg::addr_t address,
    input  cpu_isa_pkg::byte_t wdata,
    input  logic               nwrite,
    output cpu_isa_pkg::byte_t rdata
);

    cpu_isa_pkg::byte_t mem [65536];

    assign rdata = mem[address]; // Answers in the same cycle

    always @(posedge clock)
    begin
        if (!nwrite)
            mem[address] <= wdata;
    end

    // Background pattern from both address bytes
    task automatic fill();
        for (int i = 0; i < 65536; i++)
            mem[i] = i[15:8] ^ i[7:0] ^ 8'h5A;
    endtask

    task automatic load_byte(cpu_isa_pkg::addr_t a, cpu_isa_pkg::byte_t d);
        mem[a] = d;
    endtask

endmodule

`default_nettype wire

/* bench/tb_cpu_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_core;

    logic               clock;
    logic               arst_n;
    cpu_isa_pkg::byte_t db_rdata;
    cpu_isa_pkg::addr_t db_address;
    cpu_isa_pkg::byte_t db_wdata;
    logic               db_nread;
    logic               db_nwrite;
    logic               halted;

    int                 seed = 32'h9407_d1da;
    int                 errors = 0;
    int                 cycles = 0;
    int                 n_reads = 0;
    int                 n_writes = 0;
    int                 rd_count = 0;
    int                 wr_count = 0;
    bit                 build_done = 0;
    cpu_isa_pkg::addr_t pc = cpu_isa_pkg::reset_pc;
    cpu_isa_pkg::byte_t regs [8];
    cpu_isa_pkg::byte_t shadow [65536];
    logic               mz;
    logic               mc;
    cpu_isa_pkg::addr_t exp_raddr [1024];
    cpu_isa_pkg::addr_t exp_waddr [256];
    cpu_isa_pkg::byte_t exp_wdata [256];
    int                 exp_wtest [256];
    int                 test_last [3];
    string              test_names [3] = '{"alu", "moves", "jumps"};

    cpu_core uut (
        .clock      (clock),
        .arst_n     (arst_n),
        .db_rdata   (db_rdata),
        .db_address (db_address),
        .db_wdata   (db_wdata),
        .db_nread   (db_nread),
        .db_nwrite  (db_nwrite),
        .halted     (halted)
    );

    bench_memory u_memory (
        .clock   (clock),
        .address (db_address),
        .wdata   (db_wdata),
        .nwrite  (db_nwrite),
        .rdata   (db_rdata)
    );

    always #4 clock = ~clock;

    // Result in bits 7:0, then c, h, n, z above it
    function automatic logic [11:0] alu_model(int op, logic [7:0] a, logic [7:0] b, logic cin);
        int         s;
        int         hs;
        int         ci;
        logic [7:0] res;
        logic       z;
        logic       n;
        logic       h;
        logic       c;
        ci = (op == 1 || op == 3) ? int'(cin) : 0;
        s  = 0;
        n  = 0;
        h  = 0;
        c  = 0;
        case (op)
            0, 1:
            begin
                s   = a + b + ci;
                hs  = a[3:0] + b[3:0] + ci;
                res = s[7:0];
                c   = (s > 255);
                h   = (hs > 15);
            end
            2, 3, 7:
            begin
                s   = int'(a) - int'(b) - ci;
                hs  = int'(a[3:0]) - int'(b[3:0]) - ci;
                res = (op == 7) ? a : s[7:0];
                n   = 1;
                c   = (s < 0);
                h   = (hs < 0);
            end
            4:
            begin
                res = a & b;
                h   = 1;
            end
            5: res = a ^ b;
            default: res = a | b;
        endcase
        z = (op == 7) ? (s[7:0] == 8'd0) : (res == 8'd0); // CP compares the difference
        return {z, n, h, c, res};
    endfunction

    function automatic logic [7:0] rnd();
        return $random(seed);
    endfunction

    task automatic put(logic [7:0] b, bit on_path);
        u_memory.load_byte(pc, b);
        shadow[pc] = b;
        if (on_path)
        begin
            exp_raddr[n_reads] = pc;
            n_reads++;
        end
        pc++;
    endtask

    task automatic ld_imm(int r, logic [7:0] v);
        put(8'h06 | 8'(r << 3), 1);
        put(v, 1);
        regs[r] = v;
        cycles += 3;
    endtask

    task automatic ld_rr(int d, int s);
        put(8'h40 | 8'(d << 3) | 8'(s), 1);
        regs[d] = regs[s];
        cycles += 2;
    endtask

    task automatic ld_mem(int d);
        put(8'h46 | 8'(d << 3), 1);
        exp_raddr[n_reads] = {regs[4], regs[5]};
        n_reads++;
        regs[d] = shadow[{regs[4], regs[5]}];
        cycles += 2;
    endtask

    task automatic apply_alu(int op, logic [7:0] b);
        logic [11:0] r;
        r       = alu_model(op, regs[7], b, mc);
        regs[7] = r[7:0];
        mz      = r[11];
        mc      = r[8];
    endtask

    task automatic alu_reg(int op, int s);
        put(8'h80 | 8'(op << 3) | 8'(s), 1);
        apply_alu(op, regs[s]);
        cycles += 2;
    endtask

    task automatic alu_imm(int op, logic [7:0] v);
        put(8'hC6 | 8'(op << 3), 1);
        put(v, 1);
        apply_alu(op, v);
        cycles += 3;
    endtask

    // Each store gets its own address in page 0x80
    task automatic store(int s, int t);
        ld_imm(4, 8'h80);
        ld_imm(5, 8'(n_writes));
        put(8'h70 | 8'(s), 1);
        exp_waddr[n_writes] = {regs[4], regs[5]};
        exp_wdata[n_writes] = regs[s];
        exp_wtest[n_writes] = t;
        shadow[{regs[4], regs[5]}] = regs[s];
        test_last[t] = n_writes;
        n_writes++;
        cycles += 2;
    endtask

    task automatic jump_case(int cc, bit t, int k);
        logic [7:0]  v;
        logic [7:0]  mt;
        logic [7:0]  nt;
        logic [15:0] l1;
        logic [15:0] l2;
        bit          want_z;
        bit          want_c;
        bit          taken;
        v      = rnd() & 8'h7F;
        mt     = 8'hA0 + 8'(k);
        nt     = 8'h50 + 8'(k);
        want_z = (cc < 2) ? ((cc == 1) ? t : !t) : 0;
        want_c = (cc >= 2) ? ((cc == 3) ? t : !t) : 0;
        ld_imm(7, want_c || want_z ? v : v + 8'd1);
        alu_imm(7, want_c ? v + 8'd1 : v);
        case (cc)
            0: taken = !mz;
            1: taken = mz;
            2: taken = !mc;
            default: taken = mc;
        endcase
        l1 = pc + 16'd8;
        l2 = pc + 16'd10;
        put(8'hC2 | 8'(cc << 3), 1); // Target goes high byte first
        put(l1[15:8], 1);
        put(l1[7:0], 1);
        cycles += 4;
        if (taken)
        begin
            put(8'h3E, 0);
            put(nt, 0);
            put(8'hC3, 0);
            put(l2[15:8], 0);
            put(l2[7:0], 0);
            ld_imm(7, mt);
        end
        else
        begin
            ld_imm(7, nt);
            put(8'hC3, 1);
            put(l2[15:8], 1);
            put(l2[7:0], 1);
            cycles += 4;
            put(8'h3E, 0);
            put(mt, 0);
        end
        store(7, 2);
    endtask

    task automatic build_program();
        int tmp;
        int k;
        for (int op = 0; op < 8; op++)
        begin
            if (op == 1 || op == 3)
            begin
                ld_imm(7, 8'h00);
                alu_imm(7, 8'h01); // Borrow sets C
            end
            ld_imm(7, rnd());
            ld_imm(0, rnd());
            alu_reg(op, 0);
            store(7, 0);
            if (op == 1 || op == 3)
            begin
                ld_imm(7, 8'h10);
                alu_imm(7, 8'hF0);
            end
            alu_imm(op, rnd());
            store(7, 0);
        end
        for (int r = 0; r < 8; r++)
        begin
            if (r != 6)
            begin
                tmp = (r == 3) ? 2 : 3;
                ld_imm(r, rnd());
                ld_rr(tmp, r);
                store(tmp, 1);
                ld_mem(r);
                ld_rr(tmp, r);
                store(tmp, 1);
            end
        end
        k = 0;
        for (int cc = 0; cc < 4; cc++)
        begin
            jump_case(cc, 1, k);
            jump_case(cc, 0, k + 1);
            k += 2;
        end
        put(cpu_isa_pkg::op_halt, 1);
        cycles += 1;
    endtask

    initial
    begin
        clock  = 0;
        arst_n = 0;
        mz     = 0;
        mc     = 0;
        for (int i = 0; i < 8; i++)
            regs[i] = '0;
        u_memory.fill();
        for (int i = 0; i < 65536; i++)
            shadow[i] = u_memory.mem[i];
        build_program();
        build_done = 1;
        repeat (3) @(posedge clock);
        arst_n <= 1;
    end

    always @(posedge clock)
    begin
        if (arst_n && !db_nread)
            rd_count <= rd_count + 1;
        if (arst_n && !db_nwrite)
        begin
            if (wr_count < n_writes && wr_count == test_last[exp_wtest[wr_count]])
                $display("Test %s finished at store %0d", test_names[exp_wtest[wr_count]],
                         wr_count);
            wr_count <= wr_count + 1;
        end
    end

    a_idle_after_reset: assert property (@(posedge clock) $rose(arst_n) |-> db_nread && db_nwrite)
        else
        begin
            errors++;
            $display("A strobe was low in the first cycle after reset");
        end

    a_strobes_apart: assert property (@(posedge clock) disable iff (!arst_n)
        db_nread || db_nwrite)
        else
        begin
            errors++;
            $display("Read and write strobes were low together");
        end

    a_read_count: assert property (@(posedge clock) disable iff (!arst_n)
        !db_nread |-> rd_count < n_reads)
        else
        begin
            errors++;
            $display("Bus read after the end of the program");
        end

    a_read_addr: assert property (@(posedge clock) disable iff (!arst_n)
        !db_nread |-> db_address == exp_raddr[rd_count])
        else
        begin
            errors++;
            $display("Fail read_order expected %h actual %h", exp_raddr[$sampled(rd_count)],
                     $sampled(db_address));
        end

    a_write_count: assert property (@(posedge clock) disable iff (!arst_n)
        !db_nwrite |-> wr_count < n_writes)
        else
        begin
            errors++;
            $display("Unexpected extra bus write");
        end

    a_write_addr: assert property (@(posedge clock) disable iff (!arst_n)
        !db_nwrite |-> db_address == exp_waddr[wr_count])
        else
        begin
            errors++;
            $display("Fail %s expected %h actual %h",
                     test_names[exp_wtest[$sampled(wr_count)]],
                     exp_waddr[$sampled(wr_count)], $sampled(db_address));
        end

    a_write_data: assert property (@(posedge clock) disable iff (!arst_n)
        !db_nwrite |-> db_wdata == exp_wdata[wr_count])
        else
        begin
            errors++;
            $display("Fail %s expected %h actual %h",
                     test_names[exp_wtest[$sampled(wr_count)]],
                     exp_wdata[$sampled(wr_count)], $sampled(db_wdata));
        end

    a_halt_quiet: assert property (@(posedge clock) disable iff (!arst_n)
        halted |-> db_nread && db_nwrite ##1 halted)
        else
        begin
            errors++;
            $display("Bus activity or exit after HALT");
        end

    // Reset, one idle cycle, the program, then some cycles parked in halt
    initial
    begin
        int limit;
        wait (build_done);
        limit = cycles + 3 + 1 + 16;
        repeat (limit) @(posedge clock);
        #1;
        if (!halted)
        begin
            errors++;
            $display("Core did not halt within %0d cycles", limit);
        end
        if (rd_count != n_reads || wr_count != n_writes)
        begin
            errors++;
            $display("Bus cycle count off: %0d of %0d reads, %0d of %0d writes",
                     rd_count, n_reads, wr_count, n_writes);
        end
        $display("Test halt finished, halted=%0b", halted);
        $display("Totals: %0d reads, %0d writes, %0d errors", rd_count, wr_count, errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
logic/cpu_isa_pkg.sv
logic/cpu_ctrl_pkg.sv
logic/alu.sv
logic/reg_file.sv
logic/datapath.sv
logic/sequencer.sv
logic/cpu_core.sv
bench/bench_memory.sv
bench/tb_cpu_core.sv

/* Bender.yml */
package:
  name: cpu_core

sources:
  - files:
      - logic/cpu_isa_pkg.sv
      - logic/cpu_ctrl_pkg.sv
      - logic/alu.sv
      - logic/reg_file.sv
      - logic/datapath.sv
      - logic/sequencer.sv
      - logic/cpu_core.sv
  - target: test
    files:
      - bench/bench_memory.sv
      - bench/tb_cpu_core.sv
